/* common/axis_out_pkg.sv */
// axis_out_pkg
// widths, register map and bus structs shared by the AXI-Stream output peripheral

package axis_out_pkg;

   // word and beat widths
   localparam int DATA_W  = 32;
   localparam int TDATA_W = 8;
   localparam int LANES   = DATA_W / TDATA_W;
   localparam int LEVEL_W = 16;
   localparam int ADDR_W  = 4;

   // register map
   localparam logic [ADDR_W-1:0] CSR_SOFT_RESET = 4'd0;
   localparam logic [ADDR_W-1:0] CSR_ENABLE     = 4'd1;
   localparam logic [ADDR_W-1:0] CSR_MODE       = 4'd2;
   localparam logic [ADDR_W-1:0] CSR_NWORDS     = 4'd3;
   localparam logic [ADDR_W-1:0] CSR_THRESHOLD  = 4'd4;
   localparam logic [ADDR_W-1:0] CSR_DATA       = 4'd5;
   localparam logic [ADDR_W-1:0] CSR_FULL       = 4'd6;
   localparam logic [ADDR_W-1:0] CSR_EMPTY      = 4'd7;
   localparam logic [ADDR_W-1:0] CSR_LEVEL      = 4'd8;

   typedef struct packed {
      logic              wen;
      logic              ren;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } csr_req_t;

   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic              wready;
   } csr_rsp_t;

   typedef struct packed {
      logic               soft_reset;
      logic               enable;
      logic               mode;
      logic [DATA_W-1:0]  nwords;
      logic [LEVEL_W-1:0] threshold;
   } axis_cfg_t;

   // status as seen from the write clock
   typedef struct packed {
      logic               full;
      logic               empty;
      logic [LEVEL_W-1:0] level;
   } fifo_stat_t;

   typedef struct packed {
      logic [TDATA_W-1:0] tdata;
      logic               tlast;
   } axis_beat_t;

endpackage

/* verilog/bit_sync.sv */
// bit_sync
// two-flop level synchronizer into the destination clock

module bit_sync #(
   parameter int WIDTH = 1
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic [WIDTH-1:0] d_i,
   output logic [WIDTH-1:0] q_o
);

   logic [WIDTH-1:0] meta_q;
   logic [WIDTH-1:0] sync_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= d_i;
         sync_q <= meta_q;
      end
   end

   assign q_o = sync_q;

endmodule

/* fifo_async/dual_clock_ram.sv */
// dual_clock_ram
// simple dual port ram, write and read ports on independent clocks

module dual_clock_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              w_clk_i,
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_clk_i,
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // registered read, data follows r_en_i by one cycle
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* fifo_async/gray_fifo_async.sv */
// gray_fifo_async
// dual clock fifo, full words in and single bytes out, lane 0 first
// pointers cross between clocks as gray code through flop pairs

module gray_fifo_async #(
   parameter int FIFO_ADDR_W = 6
) (
   input  logic                              w_clk_i,
   input  logic                              w_rst_i,
   input  logic                              w_en_i,
   input  logic [axis_out_pkg::DATA_W-1:0]   w_data_i,
   output axis_out_pkg::fifo_stat_t          w_stat_o,
   input  logic                              r_clk_i,
   input  logic                              r_rst_i,
   input  logic                              r_en_i,
   output logic [axis_out_pkg::TDATA_W-1:0]  r_data_o,
   output logic                              r_empty_o
);

   localparam int LANES      = axis_out_pkg::LANES;
   localparam int TDATA_W    = axis_out_pkg::TDATA_W;
   localparam int LEVEL_W    = axis_out_pkg::LEVEL_W;
   localparam int LANE_W     = $clog2(LANES);
   localparam int RAM_ADDR_W = FIFO_ADDR_W - LANE_W;
   // word pointer on the write side, byte pointer on the read side
   localparam int WP_W       = RAM_ADDR_W + 1;
   localparam int RP_W       = FIFO_ADDR_W + 1;

   logic [WP_W-1:0] w_ptr_q;
   logic [WP_W-1:0] w_ptr_nxt;
   logic [WP_W-1:0] w_gray_q;
   logic [RP_W-1:0] r_gray_w1_q;
   logic [RP_W-1:0] r_gray_w2_q;
   logic [RP_W-1:0] r_ptr_w;
   logic [RP_W-1:0] w_level;
   logic            w_full;
   logic            w_push;

   logic [RP_W-1:0] r_ptr_q;
   logic [RP_W-1:0] r_ptr_nxt;
   logic [RP_W-1:0] r_gray_q;
   logic [WP_W-1:0] w_gray_r1_q;
   logic [WP_W-1:0] w_gray_r2_q;
   logic [WP_W-1:0] w_ptr_r;
   logic            r_empty;
   logic            r_pop;
   logic [LANE_W-1:0] r_lane_q;
   logic [LANES-1:0][TDATA_W-1:0] bank_rdata;

   // write side
   assign w_push    = w_en_i & ~w_full;
   assign w_ptr_nxt = w_ptr_q + 1'b1;

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_ptr_q     <= '0;
         w_gray_q    <= '0;
         r_gray_w1_q <= '0;
         r_gray_w2_q <= '0;
      end else begin
         if (w_push) begin
            w_ptr_q  <= w_ptr_nxt;
            w_gray_q <= w_ptr_nxt ^ (w_ptr_nxt >> 1);
         end
         r_gray_w1_q <= r_gray_q;
         r_gray_w2_q <= r_gray_w1_q;
      end
   end

   always_comb begin
      r_ptr_w[RP_W-1] = r_gray_w2_q[RP_W-1];
      for (int i = RP_W - 2; i >= 0; i--) begin
         r_ptr_w[i] = r_ptr_w[i+1] ^ r_gray_w2_q[i];
      end
   end

   // a partly read word still holds its slot
   assign w_full  = (w_ptr_q[WP_W-1] != r_ptr_w[RP_W-1]) &&
                    (w_ptr_q[WP_W-2:0] == r_ptr_w[RP_W-2:LANE_W]);
   assign w_level = {w_ptr_q, {LANE_W{1'b0}}} - r_ptr_w;

   assign w_stat_o.full  = w_full;
   assign w_stat_o.empty = (w_level == '0);
   assign w_stat_o.level = LEVEL_W'(w_level);

   // read side
   assign r_ptr_nxt = r_ptr_q + 1'b1;
   assign r_empty   = (r_ptr_q == {w_ptr_r, {LANE_W{1'b0}}});
   assign r_pop     = r_en_i & ~r_empty;

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_ptr_q     <= '0;
         r_gray_q    <= '0;
         w_gray_r1_q <= '0;
         w_gray_r2_q <= '0;
      end else begin
         if (r_pop) begin
            r_ptr_q  <= r_ptr_nxt;
            r_gray_q <= r_ptr_nxt ^ (r_ptr_nxt >> 1);
         end
         w_gray_r1_q <= w_gray_q;
         w_gray_r2_q <= w_gray_r1_q;
      end
   end

   always_comb begin
      w_ptr_r[WP_W-1] = w_gray_r2_q[WP_W-1];
      for (int i = WP_W - 2; i >= 0; i--) begin
         w_ptr_r[i] = w_ptr_r[i+1] ^ w_gray_r2_q[i];
      end
   end

   // remember which bank answers the current read
   always_ff @(posedge r_clk_i) begin
      if (r_pop) begin
         r_lane_q <= r_ptr_q[LANE_W-1:0];
      end
   end

   assign r_data_o  = bank_rdata[r_lane_q];
   assign r_empty_o = r_empty;

   // one byte bank per lane, all written together
   for (genvar p = 0; p < LANES; p++) begin : gen_bank
      localparam logic [LANE_W-1:0] LANE = LANE_W'(p);

      dual_clock_ram #(
         .DATA_W(TDATA_W),
         .ADDR_W(RAM_ADDR_W)
      ) i_ram (
         .w_clk_i (w_clk_i),
         .w_en_i  (w_push),
         .w_addr_i(w_ptr_q[RAM_ADDR_W-1:0]),
         .w_data_i(w_data_i[p*TDATA_W +: TDATA_W]),
         .r_clk_i (r_clk_i),
         .r_en_i  (r_pop && (r_ptr_q[LANE_W-1:0] == LANE)),
         .r_addr_i(r_ptr_q[FIFO_ADDR_W-1:LANE_W]),
         .r_data_o(bank_rdata[p])
      );
   end

endmodule

/* verilog/axis_out_csrs.sv */
// axis_out_csrs
// register file for the stream output peripheral, clk_i domain
// configuration registers, cpu data push, status readback and interrupt

module axis_out_csrs (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  axis_out_pkg::csr_req_t   csr_req_i,
   output axis_out_pkg::csr_rsp_t   csr_rsp_o,
   input  axis_out_pkg::fifo_stat_t stat_i,
   output axis_out_pkg::axis_cfg_t  cfg_o,
   output logic                     data_push_o,
   output logic [axis_out_pkg::DATA_W-1:0] data_o,
   output logic                     interrupt_o
);

   localparam int DATA_W  = axis_out_pkg::DATA_W;
   localparam int LEVEL_W = axis_out_pkg::LEVEL_W;

   axis_out_pkg::axis_cfg_t cfg_q;
   logic                    rvalid_q;
   logic [DATA_W-1:0]       rdata_q;

   // configuration writes
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (csr_req_i.wen) begin
         case (csr_req_i.addr)
            axis_out_pkg::CSR_SOFT_RESET: begin
               cfg_q.soft_reset <= csr_req_i.wdata[0];
            end
            axis_out_pkg::CSR_ENABLE: begin
               cfg_q.enable <= csr_req_i.wdata[0];
            end
            axis_out_pkg::CSR_MODE: begin
               cfg_q.mode <= csr_req_i.wdata[0];
            end
            axis_out_pkg::CSR_NWORDS: begin
               cfg_q.nwords <= csr_req_i.wdata;
            end
            axis_out_pkg::CSR_THRESHOLD: begin
               cfg_q.threshold <= csr_req_i.wdata[LEVEL_W-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   assign cfg_o = cfg_q;

   // data word goes straight to the fifo, dropped while full
   assign data_push_o = csr_req_i.wen &&
                        (csr_req_i.addr == axis_out_pkg::CSR_DATA) &&
                        !stat_i.full;
   assign data_o      = csr_req_i.wdata;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= csr_req_i.ren;
      end
   end

   // status read mux, answer one cycle after ren
   always_ff @(posedge clk_i) begin
      if (csr_req_i.ren) begin
         case (csr_req_i.addr)
            axis_out_pkg::CSR_FULL:  rdata_q <= DATA_W'(stat_i.full);
            axis_out_pkg::CSR_EMPTY: rdata_q <= DATA_W'(stat_i.empty);
            axis_out_pkg::CSR_LEVEL: rdata_q <= DATA_W'(stat_i.level);
            default:                 rdata_q <= '0;
         endcase
      end
   end

   assign csr_rsp_o.rvalid = rvalid_q;
   assign csr_rsp_o.rdata  = rdata_q;
   assign csr_rsp_o.wready = ~stat_i.full;

   // low fill level interrupt, only while the peripheral is enabled
   assign interrupt_o = cfg_q.enable && (stat_i.level <= cfg_q.threshold);

endmodule

/* verilog/axis_out_sender.sv */
// axis_out_sender
// drains the fifo onto the output stream, counts beats and marks tlast
// bytes past nwords are read and dropped without tvalid

module axis_out_sender (
   input  logic                              clk_i,
   input  logic                              rst_i,
   input  logic                              sw_rst_i,
   input  logic                              enable_i,
   input  logic [axis_out_pkg::DATA_W-1:0]   nwords_i,
   input  logic                              fifo_empty_i,
   input  logic [axis_out_pkg::TDATA_W-1:0]  fifo_data_i,
   output logic                              fifo_read_o,
   output logic                              axis_tvalid_o,
   output axis_out_pkg::axis_beat_t          axis_beat_o,
   input  logic                              axis_tready_i
);

   localparam logic ST_IDLE    = 1'b0;
   localparam logic ST_PRESENT = 1'b1;

   logic                            state_q;
   logic                            state_d;
   logic [axis_out_pkg::DATA_W-1:0] beat_cnt_q;
   logic                            in_frame;

   // counter holds the number of bytes fetched so far
   assign in_frame = (beat_cnt_q <= nwords_i);

   always_comb begin
      state_d       = state_q;
      fifo_read_o   = 1'b0;
      axis_tvalid_o = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (!fifo_empty_i) begin
               fifo_read_o = 1'b1;
               state_d     = ST_PRESENT;
            end
         end
         default: begin
            if (in_frame) begin
               axis_tvalid_o = enable_i;
               if (axis_tready_i && enable_i) begin
                  if (fifo_empty_i) begin
                     state_d = ST_IDLE;
                  end else begin
                     fifo_read_o = 1'b1;
                  end
               end
            end else if (fifo_empty_i) begin
               state_d = ST_IDLE;
            end else begin
               // padding, one byte per cycle
               fifo_read_o = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || sw_rst_i) begin
         state_q    <= ST_IDLE;
         beat_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (fifo_read_o) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

   assign axis_beat_o.tdata = fifo_data_i;
   assign axis_beat_o.tlast = axis_tvalid_o && (beat_cnt_q == nwords_i);

endmodule

/* verilog/axistream_out.sv */
// axistream_out
// AXI-Stream output peripheral, cpu or stream words out as bytes on axis_clk_i

module axistream_out #(
   parameter int FIFO_ADDR_W = 6
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            axis_clk_i,
   input  logic                            axis_rst_i,
   input  axis_out_pkg::csr_req_t          csr_req_i,
   output axis_out_pkg::csr_rsp_t          csr_rsp_o,
   input  logic                            sys_tvalid_i,
   input  logic [axis_out_pkg::DATA_W-1:0] sys_tdata_i,
   output logic                            sys_tready_o,
   output logic                            axis_tvalid_o,
   output axis_out_pkg::axis_beat_t        axis_beat_o,
   input  logic                            axis_tready_i,
   output logic                            interrupt_o
);

   localparam int DATA_W  = axis_out_pkg::DATA_W;
   localparam int TDATA_W = axis_out_pkg::TDATA_W;

   axis_out_pkg::axis_cfg_t  cfg;
   axis_out_pkg::fifo_stat_t stat;

   logic                cpu_push;
   logic [DATA_W-1:0]   cpu_data;
   logic                fifo_write;
   logic [DATA_W-1:0]   fifo_wdata;

   logic                axis_sw_rst;
   logic                axis_enable;
   logic [DATA_W-1:0]   axis_nwords;
   logic                axis_fifo_empty;
   logic                axis_fifo_read;
   logic [TDATA_W-1:0]  axis_fifo_data;

   axis_out_csrs i_csrs (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .csr_req_i  (csr_req_i),
      .csr_rsp_o  (csr_rsp_o),
      .stat_i     (stat),
      .cfg_o      (cfg),
      .data_push_o(cpu_push),
      .data_o     (cpu_data),
      .interrupt_o(interrupt_o)
   );

   // input stream only accepted in stream mode
   assign sys_tready_o = ~stat.full & cfg.enable & cfg.mode;

   // write source follows the mode register
   assign fifo_write = ((cpu_push & ~cfg.mode) | (sys_tvalid_i & sys_tready_o)) & cfg.enable;
   assign fifo_wdata = cfg.mode ? sys_tdata_i : cpu_data;

   // control registers into the axis clock
   bit_sync #(.WIDTH(1)) i_sync_sw_rst (
      .clk_i(axis_clk_i),
      .rst_i(axis_rst_i),
      .d_i  (cfg.soft_reset),
      .q_o  (axis_sw_rst)
   );

   bit_sync #(.WIDTH(1)) i_sync_enable (
      .clk_i(axis_clk_i),
      .rst_i(axis_rst_i),
      .d_i  (cfg.enable),
      .q_o  (axis_enable)
   );

   bit_sync #(.WIDTH(DATA_W)) i_sync_nwords (
      .clk_i(axis_clk_i),
      .rst_i(axis_rst_i),
      .d_i  (cfg.nwords),
      .q_o  (axis_nwords)
   );

   gray_fifo_async #(
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) i_fifo (
      .w_clk_i  (clk_i),
      .w_rst_i  (rst_i | cfg.soft_reset),
      .w_en_i   (fifo_write),
      .w_data_i (fifo_wdata),
      .w_stat_o (stat),
      .r_clk_i  (axis_clk_i),
      .r_rst_i  (axis_rst_i | axis_sw_rst),
      .r_en_i   (axis_fifo_read),
      .r_data_o (axis_fifo_data),
      .r_empty_o(axis_fifo_empty)
   );

   axis_out_sender i_sender (
      .clk_i        (axis_clk_i),
      .rst_i        (axis_rst_i),
      .sw_rst_i     (axis_sw_rst),
      .enable_i     (axis_enable),
      .nwords_i     (axis_nwords),
      .fifo_empty_i (axis_fifo_empty),
      .fifo_data_i  (axis_fifo_data),
      .fifo_read_o  (axis_fifo_read),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_beat_o  (axis_beat_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

/* dv/axistream_out_tb.sv */
// axistream_out_tb
// directed testbench for the AXI-Stream output peripheral, byte scoreboard on the output

module axistream_out_tb;

   localparam int FIFO_ADDR_W = 6;
   localparam int FIFO_WORDS  = (2 ** FIFO_ADDR_W) / axis_out_pkg::LANES;
   localparam int MAX_WAIT    = 2000;

   logic                            clk_i      = 1'b0;
   logic                            rst_i      = 1'b1;
   logic                            axis_clk_i = 1'b0;
   logic                            axis_rst_i = 1'b1;
   axis_out_pkg::csr_req_t          csr_req;
   axis_out_pkg::csr_rsp_t          csr_rsp;
   logic                            sys_tvalid_i;
   logic [axis_out_pkg::DATA_W-1:0] sys_tdata_i;
   logic                            sys_tready_o;
   logic                            axis_tvalid_o;
   axis_out_pkg::axis_beat_t        axis_beat_o;
   logic                            axis_tready_i;
   logic                            interrupt_o;

   // scoreboard of bytes still expected on the output
   axis_out_pkg::axis_beat_t exp_q[$];
   int                       beats_queued;
   logic [31:0]              rng = 32'd90889;
   int                       mismatches;
   int                       failures;

   always #4 clk_i = ~clk_i;
   always #5 axis_clk_i = ~axis_clk_i;

   axistream_out #(
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) i_dut (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .axis_clk_i   (axis_clk_i),
      .axis_rst_i   (axis_rst_i),
      .csr_req_i    (csr_req),
      .csr_rsp_o    (csr_rsp),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .sys_tready_o (sys_tready_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_beat_o  (axis_beat_o),
      .axis_tready_i(axis_tready_i),
      .interrupt_o  (interrupt_o)
   );

   // xorshift32
   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic count_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
      $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
      mismatches++;
   endtask

   task automatic raise_error(input string what);
      $display("error at %0t: %s", $time, what);
      failures++;
   endtask

   task automatic csr_write(input logic [axis_out_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] data);
      @(negedge clk_i);
      csr_req.wen   = 1'b1;
      csr_req.addr  = addr;
      csr_req.wdata = data;
      @(negedge clk_i);
      csr_req.wen = 1'b0;
   endtask

   task automatic csr_read(input logic [axis_out_pkg::ADDR_W-1:0] addr,
                           output logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge clk_i);
      csr_req.ren  = 1'b1;
      csr_req.addr = addr;
      @(negedge clk_i);
      csr_req.ren = 1'b0;
      while (!csr_rsp.rvalid && waited < 10) begin
         @(negedge clk_i);
         waited++;
      end
      if (!csr_rsp.rvalid) begin
         raise_error("register read got no response");
         data = '0;
      end else begin
         data = csr_rsp.rdata;
      end
   endtask

   task automatic soft_reset();
      csr_write(axis_out_pkg::CSR_SOFT_RESET, 32'd1);
      // give the synchronized copy time to reach the axis side
      repeat (6) @(negedge clk_i);
      csr_write(axis_out_pkg::CSR_SOFT_RESET, 32'd0);
      repeat (6) @(negedge clk_i);
      exp_q.delete();
      beats_queued = 0;
   endtask

   task automatic configure(input logic enable, input logic mode, input int nwords,
                            input int threshold);
      csr_write(axis_out_pkg::CSR_ENABLE, 32'(enable));
      csr_write(axis_out_pkg::CSR_MODE, 32'(mode));
      csr_write(axis_out_pkg::CSR_NWORDS, 32'(nwords));
      csr_write(axis_out_pkg::CSR_THRESHOLD, 32'(threshold));
   endtask

   // lane 0 first, beats past nwords are padding and never appear
   task automatic queue_word(input logic [31:0] word, input int nwords);
      axis_out_pkg::axis_beat_t beat;
      for (int lane = 0; lane < axis_out_pkg::LANES; lane++) begin
         beats_queued++;
         beat.tdata = word[lane*8 +: 8];
         beat.tlast = (beats_queued == nwords);
         if (beats_queued <= nwords) begin
            exp_q.push_back(beat);
         end
      end
   endtask

   task automatic stream_word(input logic [31:0] word);
      int waited;
      waited = 0;
      @(negedge clk_i);
      sys_tvalid_i = 1'b1;
      sys_tdata_i  = word;
      while (!sys_tready_o && waited < MAX_WAIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!sys_tready_o) begin
         raise_error("input stream never became ready");
      end
      // transfer happens on the rising edge before the next falling edge
      @(negedge clk_i);
      sys_tvalid_i = 1'b0;
   endtask

   task automatic collect_beats(input int count, input logic random_ready);
      int                       got;
      int                       cycles;
      logic                     held;
      logic                     ready;
      logic [31:0]              rnd;
      axis_out_pkg::axis_beat_t held_beat;
      axis_out_pkg::axis_beat_t expected;
      got       = 0;
      cycles    = 0;
      held      = 1'b0;
      held_beat = '0;
      while (got < count && cycles < MAX_WAIT) begin
         @(negedge axis_clk_i);
         cycles++;
         if (held && !axis_tvalid_o) begin
            raise_error("tvalid dropped while tready was low");
         end
         if (held && axis_tvalid_o && axis_beat_o !== held_beat) begin
            count_mismatch("axis_beat_o while stalled", axis_beat_o, held_beat);
         end
         ready = 1'b1;
         if (random_ready) begin
            rnd   = next_random();
            ready = rnd[0];
         end
         axis_tready_i = ready;
         if (axis_tvalid_o && ready) begin
            if (exp_q.size() == 0) begin
               raise_error("output beat with no expected byte");
            end else begin
               expected = exp_q.pop_front();
               if (axis_beat_o.tdata !== expected.tdata) begin
                  count_mismatch("axis_beat_o.tdata", axis_beat_o.tdata, expected.tdata);
               end
               if (axis_beat_o.tlast !== expected.tlast) begin
                  count_mismatch("axis_beat_o.tlast", axis_beat_o.tlast, expected.tlast);
               end
            end
            got++;
            held = 1'b0;
         end else begin
            held      = axis_tvalid_o;
            held_beat = axis_beat_o;
         end
      end
      if (got < count) begin
         raise_error("timed out waiting for output beats");
      end
   endtask

   task automatic expect_quiet(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge axis_clk_i);
         axis_tready_i = 1'b1;
         if (axis_tvalid_o !== 1'b0) begin
            raise_error("unexpected beat on the output stream");
         end
      end
   endtask

   task automatic wait_for_empty();
      logic [31:0] data;
      int          polls;
      data  = '0;
      polls = 0;
      while (data[0] !== 1'b1 && polls < 50) begin
         csr_read(axis_out_pkg::CSR_EMPTY, data);
         polls++;
      end
      if (data[0] !== 1'b1) begin
         raise_error("FIFO never read back empty");
      end
   endtask

   task automatic check_after_reset();
      if (axis_tvalid_o !== 1'b0) count_mismatch("axis_tvalid_o", axis_tvalid_o, 0);
      if (sys_tready_o !== 1'b0) count_mismatch("sys_tready_o", sys_tready_o, 0);
      if (interrupt_o !== 1'b0) count_mismatch("interrupt_o", interrupt_o, 0);
      if (csr_rsp.rvalid !== 1'b0) count_mismatch("csr_rsp.rvalid", csr_rsp.rvalid, 0);
   endtask

   task automatic cpu_frame_test();
      logic [31:0] word;
      soft_reset();
      configure(1'b1, 1'b0, 8, 0);
      for (int i = 0; i < 2; i++) begin
         word = next_random();
         queue_word(word, 8);
         csr_write(axis_out_pkg::CSR_DATA, word);
      end
      collect_beats(8, 1'b0);
   endtask

   task automatic padding_test();
      logic [31:0] word;
      soft_reset();
      configure(1'b1, 1'b0, 6, 0);
      for (int i = 0; i < 2; i++) begin
         word = next_random();
         queue_word(word, 6);
         csr_write(axis_out_pkg::CSR_DATA, word);
      end
      collect_beats(6, 1'b0);
      expect_quiet(40);
      wait_for_empty();
   endtask

   task automatic stream_backpressure_test();
      logic [31:0] words [12];
      soft_reset();
      configure(1'b1, 1'b1, 48, 0);
      for (int i = 0; i < 12; i++) begin
         words[i] = next_random();
         queue_word(words[i], 48);
      end
      fork
         begin
            for (int i = 0; i < 12; i++) begin
               stream_word(words[i]);
            end
         end
         collect_beats(48, 1'b1);
      join
      wait_for_empty();
   endtask

   task automatic full_fifo_test();
      int          accepted;
      int          waited;
      logic [31:0] data;
      @(negedge axis_clk_i);
      axis_tready_i = 1'b0;
      soft_reset();
      configure(1'b1, 1'b1, 1000, 0);
      accepted = 0;
      waited   = 0;
      @(negedge clk_i);
      while (sys_tready_o && waited < MAX_WAIT) begin
         sys_tvalid_i = 1'b1;
         sys_tdata_i  = next_random();
         accepted++;
         @(negedge clk_i);
         waited++;
      end
      sys_tvalid_i = 1'b0;
      if (accepted != FIFO_WORDS) count_mismatch("accepted words", accepted, FIFO_WORDS);
      if (csr_rsp.wready !== 1'b0) count_mismatch("csr_rsp.wready", csr_rsp.wready, 0);
      if (sys_tready_o !== 1'b0) count_mismatch("sys_tready_o", sys_tready_o, 0);
      if (axis_tvalid_o !== 1'b1) count_mismatch("axis_tvalid_o", axis_tvalid_o, 1);
      csr_read(axis_out_pkg::CSR_FULL, data);
      if (data !== 32'd1) count_mismatch("CSR_FULL", data, 1);
      // the byte on the stalled output has already left the FIFO
      csr_read(axis_out_pkg::CSR_LEVEL, data);
      if (data !== 32'(4 * accepted - 1)) count_mismatch("CSR_LEVEL", data, 4 * accepted - 1);
   endtask

   task automatic interrupt_test();
      logic expected;
      int   level;
      soft_reset();
      configure(1'b1, 1'b0, 1000, 8);
      for (int n = 0; n <= 4; n++) begin
         if (n > 0) begin
            csr_write(axis_out_pkg::CSR_DATA, next_random());
         end
         repeat (4) @(negedge clk_i);
         expected = (4 * n <= 8);
         if (interrupt_o !== expected) count_mismatch("interrupt_o", interrupt_o, expected);
      end
      // stalled sender holds one byte outside the FIFO, so the level is one short
      level = 4 * 4 - 1;
      csr_write(axis_out_pkg::CSR_THRESHOLD, 32'(level));
      repeat (2) @(negedge clk_i);
      if (interrupt_o !== 1'b1) count_mismatch("interrupt_o at threshold", interrupt_o, 1);
      csr_write(axis_out_pkg::CSR_THRESHOLD, 32'(level - 1));
      repeat (2) @(negedge clk_i);
      if (interrupt_o !== 1'b0) count_mismatch("interrupt_o above threshold", interrupt_o, 0);
   endtask

   task automatic enable_off_test();
      logic [31:0] data;
      soft_reset();
      configure(1'b0, 1'b0, 8, 8);
      for (int i = 0; i < 3; i++) begin
         csr_write(axis_out_pkg::CSR_DATA, next_random());
      end
      csr_write(axis_out_pkg::CSR_MODE, 32'd1);
      @(negedge clk_i);
      sys_tvalid_i = 1'b1;
      sys_tdata_i  = next_random();
      for (int i = 0; i < 10; i++) begin
         if (sys_tready_o !== 1'b0) count_mismatch("sys_tready_o", sys_tready_o, 0);
         @(negedge clk_i);
      end
      sys_tvalid_i = 1'b0;
      csr_read(axis_out_pkg::CSR_LEVEL, data);
      if (data !== 32'd0) count_mismatch("CSR_LEVEL", data, 0);
      expect_quiet(40);
   endtask

   initial begin
      csr_req       = '0;
      sys_tvalid_i  = 1'b0;
      sys_tdata_i   = '0;
      axis_tready_i = 1'b0;
      mismatches    = 0;
      failures      = 0;
      beats_queued  = 0;
      fork
         begin
            repeat (16) @(negedge clk_i);
            rst_i = 1'b0;
         end
         begin
            repeat (16) @(negedge axis_clk_i);
            axis_rst_i = 1'b0;
         end
      join
      check_after_reset();
      cpu_frame_test();
      padding_test();
      stream_backpressure_test();
      full_fifo_test();
      interrupt_test();
      enable_off_test();
      $display("run complete: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches + failures == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* axistream_out.f */
common/axis_out_pkg.sv
verilog/bit_sync.sv
fifo_async/dual_clock_ram.sv
fifo_async/gray_fifo_async.sv
verilog/axis_out_csrs.sv
verilog/axis_out_sender.sv
verilog/axistream_out.sv
dv/axistream_out_tb.sv

/* Bender.yml */
package:
  name: axistream_out

sources:
  # shared package first, the RTL depends on it
  - common/axis_out_pkg.sv
  - verilog/bit_sync.sv
  - fifo_async/dual_clock_ram.sv
  - fifo_async/gray_fifo_async.sv
  - verilog/axis_out_csrs.sv
  - verilog/axis_out_sender.sv
  - verilog/axistream_out.sv

  - target: test
    files:
      - dv/axistream_out_tb.sv
